/* list.f */
lsq_pkg.sv
lsq_fifo.sv
store_align.sv
store_queue.sv
load_store_queue.sv
mem_issue_arbiter.sv
lsq_top.sv
tb_lsq.sv

/* load_store_queue.sv */
/*
 * Load/store queue processing block
 * Splits requests into load and store queues, blocks colliding loads
 */
`timescale 1ns/1ps
`default_nettype none

module load_store_queue import lsq_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic in_valid,
    input  wire lsq_req_t in_req,
    output logic sq_full,
    output logic lq_full,
    input  wire logic store_retire,
    output logic load_valid,
    output mem_req_t load_req,
    input  wire logic load_pop,
    output logic store_valid,
    output mem_req_t store_req,
    input  wire logic store_pop
);
    logic collision;
    logic [SQ_IDX_W-1:0] collision_index;
    logic [SQ_IDX_W-1:0] sq_oldest;
    logic [SQ_IDX_W-1:0] store_gap;
    logic store_gone;
    logic lq_valid;
    lq_entry_t lq_in;
    lq_entry_t lq_head;
    sq_entry_t sq_in;
    sq_entry_t sq_head;

    ////////////////////////////////////////////////////////////////////////////
    // Load queue
    // Tag each load with its youngest older store of same hash
    assign lq_in = '{
        addr: in_req.addr,
        fn3: in_req.fn3,
        id: in_req.id,
        store_collision: collision,
        sq_index: collision_index
    };

    lsq_fifo #(
        .DATA_TYPE (lq_entry_t),
        .DEPTH     (LQ_DEPTH)
    ) load_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (in_valid & in_req.load),
        .pop      (load_pop),
        .data_in  (lq_in),
        .data_out (lq_head),
        .valid    (lq_valid),
        .full     (lq_full)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Store queue
    assign sq_in = '{
        addr: {in_req.addr[31:2], 2'b00},
        data: in_req.data,
        be: in_req.be,
        hash: addr_hash_fn(in_req.addr)
    };

    store_queue sq (
        .clk             (clk),
        .reset           (reset),
        .push            (in_valid & in_req.store),
        .push_entry      (sq_in),
        .pop             (store_pop),
        .store_retire    (store_retire),
        .load_hash       (addr_hash_fn(in_req.addr)),
        .collision       (collision),
        .collision_index (collision_index),
        .oldest_index    (sq_oldest),
        .full            (sq_full),
        .valid           (store_valid),
        .head            (sq_head)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Output
    // Store is gone once oldest has moved past it (1..SQ_DEPTH behind)
    assign store_gap = sq_oldest - lq_head.sq_index;
    assign store_gone = (store_gap != '0) && (store_gap <= SQ_IDX_W'(SQ_DEPTH));
    assign load_valid = lq_valid & (~lq_head.store_collision | store_gone);

    assign load_req = '{
        write: 1'b0,
        addr: lq_head.addr,
        data: '0,
        be: '0,
        fn3: lq_head.fn3,
        id: lq_head.id
    };

    // fn3 and id unused on stores
    assign store_req = '{
        write: 1'b1,
        addr: sq_head.addr,
        data: sq_head.data,
        be: sq_head.be,
        fn3: '0,
        id: '0
    };

endmodule

`default_nettype wire

/* lsq_fifo.sv */
/*
 * Synchronous FIFO, circular buffer with a payload type parameter
 * Shared by the load queue and the store queue data storage
 */
`timescale 1ns/1ps
`default_nettype none

module lsq_fifo #(
    parameter type DATA_TYPE = logic [31:0],
    parameter int DEPTH = 4
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic push,
    input  wire logic pop,
    input  wire DATA_TYPE data_in,
    output DATA_TYPE data_out,
    output logic valid,
    output logic full
);
    DATA_TYPE mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    ////////////////////////////////////////////////////////////////////////////
    // Storage, written at the tail
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= data_in;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            // Wrap at DEPTH even when it is no power of two
            if (push)
                wr_ptr <= (wr_ptr == $bits(wr_ptr)'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == $bits(rd_ptr)'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head is visible right after the pushing edge
    assign data_out = mem[rd_ptr];
    assign valid = (count != '0);
    assign full = (count == $bits(count)'(DEPTH));

endmodule

`default_nettype wire

/* lsq_pkg.sv */
/*
 * Load/store queue shared definitions
 * Queue sizes, request and entry records, word address hash
 */
`default_nettype none

package lsq_pkg;

    // Queue sizes
    localparam int SQ_DEPTH = 4;
    localparam int LQ_DEPTH = 4;
    localparam int ID_W = 4;
    localparam int HASH_W = 6;
    // One spare bit so wrapped store indices still order correctly
    localparam int SQ_IDX_W = $clog2(SQ_DEPTH) + 1;

    // Request as seen by the queue; be is filled in by the input side
    typedef struct packed {
        logic load;
        logic store;
        logic [2:0] fn3;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] be;
        logic [ID_W-1:0] id;
    } lsq_req_t;

    // Store queue payload
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] be;
        logic [HASH_W-1:0] hash;
    } sq_entry_t;

    // Load queue payload, with the store it may be waiting on
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0] fn3;
        logic [ID_W-1:0] id;
        logic store_collision;
        logic [SQ_IDX_W-1:0] sq_index;
    } lq_entry_t;

    // Single memory request, load or store
    typedef struct packed {
        logic write;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] be;
        logic [2:0] fn3;
        logic [ID_W-1:0] id;
    } mem_req_t;

    // Fold word address bits 19:2 into HASH_W bits
    function automatic logic [HASH_W-1:0] addr_hash_fn(input logic [31:0] addr);
        return addr[7:2] ^ addr[13:8] ^ addr[19:14];
    endfunction

endpackage

`default_nettype wire

/* lsq_top.sv */
/*
 * Load/store queue subsystem top level
 * Input side, queues and memory issue
 */
`timescale 1ns/1ps
`default_nettype none

module lsq_top import lsq_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic req_valid,
    input  wire lsq_req_t req,
    output logic req_ready,
    input  wire logic store_retire,
    output logic mem_valid,
    output mem_req_t mem_req,
    input  wire logic mem_ready
);
    logic sq_full;
    logic lq_full;
    logic aligned_valid;
    lsq_req_t aligned_req;
    logic load_valid;
    logic store_valid;
    logic load_pop;
    logic store_pop;
    mem_req_t load_req;
    mem_req_t store_req;

    store_align input_side (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .sq_full   (sq_full),
        .lq_full   (lq_full),
        .out_valid (aligned_valid),
        .out_req   (aligned_req)
    );

    load_store_queue lsq (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (aligned_valid),
        .in_req       (aligned_req),
        .sq_full      (sq_full),
        .lq_full      (lq_full),
        .store_retire (store_retire),
        .load_valid   (load_valid),
        .load_req     (load_req),
        .load_pop     (load_pop),
        .store_valid  (store_valid),
        .store_req    (store_req),
        .store_pop    (store_pop)
    );

    mem_issue_arbiter output_side (
        .clk         (clk),
        .reset       (reset),
        .load_valid  (load_valid),
        .load_req    (load_req),
        .store_valid (store_valid),
        .store_req   (store_req),
        .load_pop    (load_pop),
        .store_pop   (store_pop),
        .mem_valid   (mem_valid),
        .mem_req     (mem_req),
        .mem_ready   (mem_ready)
    );

endmodule

`default_nettype wire

/* mem_issue_arbiter.sv */
/*
 * Output side, one memory request register
 * Loads win over stores, held stable under back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module mem_issue_arbiter import lsq_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic load_valid,
    input  wire mem_req_t load_req,
    input  wire logic store_valid,
    input  wire mem_req_t store_req,
    output logic load_pop,
    output logic store_pop,
    output logic mem_valid,
    output mem_req_t mem_req,
    input  wire logic mem_ready
);
    logic can_capture;

    // Register free, or emptying on this edge
    assign can_capture = ~mem_valid | mem_ready;
    assign load_pop = can_capture & load_valid;
    assign store_pop = can_capture & ~load_valid & store_valid;

    always_ff @(posedge clk) begin
        if (reset)
            mem_valid <= 1'b0;
        else if (can_capture)
            mem_valid <= load_valid | store_valid;
    end

    // Request held until it transfers
    always_ff @(posedge clk) begin
        if (load_pop)
            mem_req <= load_req;
        else if (store_pop)
            mem_req <= store_req;
    end

endmodule

`default_nettype wire

/* store_align.sv */
/*
 * Input side of the load/store queue
 * One-entry register, byte enables and store data lane alignment
 */
`timescale 1ns/1ps
`default_nettype none

module store_align import lsq_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic req_valid,
    input  wire lsq_req_t req,
    output logic req_ready,
    input  wire logic sq_full,
    input  wire logic lq_full,
    output logic out_valid,
    output lsq_req_t out_req
);
    logic active;
    logic held_valid;
    logic blocked;
    lsq_req_t aligned;

    // Byte enables and lane shift from size (fn3[1:0]) and addr[1:0]
    always_comb begin
        aligned = req;
        case (req.fn3[1:0])
            2'b00: begin
                aligned.be = 4'b0001 << req.addr[1:0];
                aligned.data = {24'b0, req.data[7:0]} << {req.addr[1:0], 3'b000};
            end
            2'b01: begin
                aligned.be = 4'b0011 << {req.addr[1], 1'b0};
                aligned.data = {16'b0, req.data[15:0]} << {req.addr[1], 4'b0000};
            end
            default: begin
                aligned.be = 4'b1111;
                aligned.data = req.data;
            end
        endcase
    end

    // Held request stalls when the queue it targets is full
    assign blocked = out_req.store ? sq_full : lq_full;
    assign out_valid = held_valid & ~blocked;
    // Take a new one if empty or the held one leaves this cycle
    assign req_ready = active & (~held_valid | ~blocked);

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            held_valid <= 1'b0;
        end else begin
            active <= 1'b1;
            if (req_valid & req_ready)
                held_valid <= 1'b1;
            else if (out_valid)
                held_valid <= 1'b0;
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (req_valid & req_ready)
            out_req <= aligned;
    end

endmodule

`default_nettype wire

/* store_queue.sv */
/*
 * Circular store queue with retire release counting
 * Compares an incoming load hash against every queued store
 */
`timescale 1ns/1ps
`default_nettype none

module store_queue import lsq_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic push,
    input  wire sq_entry_t push_entry,
    input  wire logic pop,
    input  wire logic store_retire,
    input  wire logic [HASH_W-1:0] load_hash,
    output logic collision,
    output logic [SQ_IDX_W-1:0] collision_index,
    output logic [SQ_IDX_W-1:0] oldest_index,
    output logic full,
    output logic valid,
    output sq_entry_t head
);
    logic [SQ_IDX_W-1:0] oldest;
    logic [SQ_IDX_W-1:0] newest;
    logic [SQ_IDX_W-1:0] released;
    logic [SQ_DEPTH-1:0] slot_valid;
    logic [HASH_W-1:0] slot_hash [SQ_DEPTH];
    logic fifo_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Data storage
    lsq_fifo #(
        .DATA_TYPE (sq_entry_t),
        .DEPTH     (SQ_DEPTH)
    ) sq_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (push),
        .pop      (pop),
        .data_in  (push_entry),
        .data_out (head),
        .valid    (fifo_valid),
        .full     (full)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Slot tracking
    // Low index bits pick the slot as the FIFO pointers advance in step
    always_ff @(posedge clk) begin
        if (reset) begin
            oldest <= '0;
            newest <= '0;
            slot_valid <= '0;
        end else begin
            if (push) begin
                slot_valid[newest[SQ_IDX_W-2:0]] <= 1'b1;
                newest <= newest + 1'b1;
            end
            if (pop) begin
                slot_valid[oldest[SQ_IDX_W-2:0]] <= 1'b0;
                oldest <= oldest + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            slot_hash[newest[SQ_IDX_W-2:0]] <= push_entry.hash;
    end

    // Stores retired by the core but not yet sent
    always_ff @(posedge clk) begin
        if (reset)
            released <= '0;
        else begin
            case ({store_retire, pop})
                2'b10: released <= released + 1'b1;
                2'b01: released <= released - 1'b1;
                default: released <= released;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Hash compare
    // Walk oldest to newest so the last hit is the youngest match
    always_comb begin
        logic [SQ_IDX_W-2:0] slot;
        collision = 1'b0;
        collision_index = oldest;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            slot = oldest[SQ_IDX_W-2:0] + (SQ_IDX_W-1)'(i);
            if (slot_valid[slot] && (slot_hash[slot] == load_hash)) begin
                collision = 1'b1;
                collision_index = oldest + SQ_IDX_W'(i);
            end
        end
    end

    assign oldest_index = oldest;
    // Head may go only once released
    assign valid = fifo_valid & (released != '0);

endmodule

`default_nettype wire

/* tb_lsq.sv */
/*
 * Self-checking random testbench for the load/store queue subsystem
 * Program-order model of stores, loads, retires and same-word ordering
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lsq import lsq_pkg::*; ();

    localparam int NUM_REQ = 300;
    localparam int CLK_PERIOD = 20;
    localparam int WATCHDOG_NS = NUM_REQ * 200 * CLK_PERIOD;

    logic clk = 1'b0;
    logic reset;
    logic req_valid;
    lsq_req_t req;
    logic req_ready;
    logic store_retire;
    logic mem_valid;
    mem_req_t mem_req;
    logic mem_ready;

    // Model state in program order
    integer seed = 54;
    mem_req_t exp_stores[$];
    mem_req_t exp_loads[$];
    // Store sequence number each load must wait for or -1
    int load_wait[$];
    int last_store[8];
    int generated = 0;
    int accepted = 0;
    int stores_accepted = 0;
    int stores_issued = 0;
    int loads_issued = 0;
    int retires_sent = 0;
    int stall_left = 0;
    logic hold_valid = 1'b0;
    mem_req_t held_req;
    logic saw_backpressure = 1'b0;

    lsq_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .store_retire (store_retire),
        .mem_valid    (mem_valid),
        .mem_req      (mem_req),
        .mem_ready    (mem_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting
    task automatic stop_failed();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t ns", what, $time);
        stop_failed();
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        stop_failed();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    // Store lands in lanes from addr[1:0] upward with one lane per byte
    function automatic mem_req_t expected_store(input lsq_req_t r);
        mem_req_t m;
        int nbytes;
        int lane;
        m = '0;
        m.write = 1'b1;
        m.addr = {r.addr[31:2], 2'b00};
        nbytes = 1 << r.fn3[1:0];
        for (int k = 0; k < nbytes; k++) begin
            lane = r.addr[1:0] + k;
            m.be[lane] = 1'b1;
            m.data[8*lane +: 8] = r.data[8*k +: 8];
        end
        return m;
    endfunction

    function automatic mem_req_t expected_load(input lsq_req_t r);
        mem_req_t m;
        m = '0;
        m.addr = r.addr;
        m.fn3 = r.fn3;
        m.id = r.id;
        return m;
    endfunction

    // Issued request against the head of its program-order list
    task automatic check_issue();
        mem_req_t exp;
        int wait_seq;
        if (mem_req.write) begin
            assert (exp_stores.size() > 0) else report_failure("store issued with none pending");
            assert (stores_issued < retires_sent)
                else report_failure("store issued before its retire pulse");
            exp = exp_stores.pop_front();
            assert (mem_req.addr == exp.addr)
                else report_mismatch("mem_req.addr", exp.addr, mem_req.addr);
            assert (mem_req.data == exp.data)
                else report_mismatch("mem_req.data", exp.data, mem_req.data);
            assert (mem_req.be == exp.be) else report_mismatch("mem_req.be", exp.be, mem_req.be);
            stores_issued++;
        end else begin
            assert (exp_loads.size() > 0) else report_failure("load issued with none pending");
            exp = exp_loads.pop_front();
            wait_seq = load_wait.pop_front();
            assert (mem_req.id == exp.id) else report_mismatch("mem_req.id", exp.id, mem_req.id);
            assert (mem_req.addr == exp.addr)
                else report_mismatch("mem_req.addr", exp.addr, mem_req.addr);
            assert (mem_req.fn3 == exp.fn3)
                else report_mismatch("mem_req.fn3", exp.fn3, mem_req.fn3);
            // Older store to the same word must be out already
            assert (stores_issued > wait_seq)
                else report_failure("load issued before an older store to the same word");
            loads_issued++;
        end
    endtask

    // Monitor sampling at the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            if (req_valid && req_ready) begin
                if (req.store) begin
                    exp_stores.push_back(expected_store(req));
                    last_store[req.addr[4:2]] = stores_accepted;
                    stores_accepted++;
                end else begin
                    exp_loads.push_back(expected_load(req));
                    load_wait.push_back(last_store[req.addr[4:2]]);
                end
                accepted++;
            end
            // Request refused by a full queue
            if (req_valid && !req_ready)
                saw_backpressure = 1'b1;
            if (hold_valid) begin
                assert (mem_valid) else report_failure("mem_valid dropped before the transfer");
                assert (mem_req == held_req) else report_mismatch("mem_req", held_req, mem_req);
            end
            if (mem_valid && mem_ready)
                check_issue();
            if (store_retire)
                retires_sent++;
            hold_valid = mem_valid && !mem_ready;
            held_req = mem_req;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    // Eight words only so same-word hits are common
    task automatic new_request();
        int word;
        int size;
        logic [1:0] offset;
        word = $unsigned($random(seed)) % 8;
        size = $unsigned($random(seed)) % 3;
        case (size)
            0: offset = $unsigned($random(seed)) % 4;
            1: offset = 2 * ($unsigned($random(seed)) % 2);
            default: offset = 2'b00;
        endcase
        req = '0;
        req.store = ($random(seed) % 2 == 0);
        req.load = ~req.store;
        req.fn3 = size;
        // Unsigned byte or half loads now and then
        if (req.load && size < 2)
            req.fn3[2] = ($random(seed) % 2 == 0);
        req.addr = 32'h0000_1000 + word * 4 + offset;
        req.data = $random(seed);
        req.id = ID_W'($random(seed));
        req_valid = 1'b1;
        generated++;
    endtask

    // Mostly random with long stalls to fill the queues
    task automatic drive_mem_ready();
        if (stall_left > 0) begin
            mem_ready = 1'b0;
            stall_left--;
        end else if ($unsigned($random(seed)) % 40 == 0) begin
            stall_left = 20 + $unsigned($random(seed)) % 16;
            mem_ready = 1'b0;
        end else begin
            mem_ready = ($unsigned($random(seed)) % 4 != 0);
        end
    endtask

    initial begin
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        store_retire = 1'b0;
        mem_ready = 1'b0;
        foreach (last_store[w])
            last_store[w] = -1;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        assert (mem_valid == 1'b0) else report_mismatch("mem_valid", 0, mem_valid);
        assert (req_ready == 1'b0) else report_mismatch("req_ready", 0, req_ready);
        while (loads_issued + stores_issued < NUM_REQ) begin
            @(posedge clk);
            #2;
            // Request held until taken
            if (req_valid && accepted == generated)
                req_valid = 1'b0;
            if (!req_valid && generated < NUM_REQ && $unsigned($random(seed)) % 4 != 0)
                new_request();
            // Never retire more stores than accepted
            store_retire = (retires_sent < stores_accepted) && ($unsigned($random(seed)) % 3 == 0);
            drive_mem_ready();
        end
        store_retire = 1'b0;
        // Nothing left in flight once every request has gone out
        assert (mem_valid == 1'b0)
            else report_failure("extra memory request pending after all requests issued");
        assert (saw_backpressure) else report_failure("req_ready never fell with full queues");
        $display("test passed");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before all requests issued");
    end

endmodule

`default_nettype wire
